// File: apb_periph.f
src/apb_periph_pkg.sv
src/apb_periph_if.sv
src/apb_periph_decoder.sv
src/apb_gpio_regs.sv
src/apb_pwm_timer.sv
src/apb_soc_ctrl.sv
src/apb_periph_subsystem.sv
verification/apb_periph_asserts.sv
verification/apb_periph_checker.sv
verification/tb_apb_periph.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the APB peripheral subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f apb_periph.f --top-module tb_apb_periph -o sim_apb_periph

./obj_dir/sim_apb_periph +verilator+error+limit+100 | tee sim.log

if grep -q '^>>> PASS$' sim.log; then
   echo "Simulation passed"
else
   echo "Simulation failed, see sim.log"
   exit 1
fi

// File: src/apb_gpio_regs.sv
// GPIO register block
// Direction and output registers, two-flop input synchronizer

module apb_gpio_regs
   import apb_periph_pkg::*;
(
   input  logic        clk_i,
   input  logic        rst_n_i,
   apb_periph_if.slave bus,
   input  gpio_vec_t   gpio_in_i,
   output gpio_vec_t   gpio_out_o,
   output gpio_vec_t   gpio_oe_o
);

   gpio_vec_t  dir_q;
   gpio_vec_t  out_q;
   gpio_vec_t  sync1_q;
   gpio_vec_t  sync2_q;
   logic       wr_en;
   logic [7:0] reg_off;

   assign reg_off = bus.paddr[7:0];
   assign wr_en = bus.psel && bus.penable && bus.pwrite;

   // Pad input synchronizer
   always_ff @(posedge clk_i) begin
      sync1_q <= gpio_in_i;
      sync2_q <= sync1_q;
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         dir_q <= '0;
         out_q <= '0;
      end else if (wr_en) begin
         case (reg_off)
            GPIO_DIR: dir_q <= bus.pwdata[NUM_GPIO-1:0];
            GPIO_OUT: out_q <= bus.pwdata[NUM_GPIO-1:0];
            // GPIO_IN is read-only
            default: begin
               dir_q <= dir_q;
            end
         endcase
      end
   end

   always_comb begin
      bus.prdata = '0;
      case (reg_off)
         GPIO_DIR: bus.prdata = apb_data_t'(dir_q);
         GPIO_OUT: bus.prdata = apb_data_t'(out_q);
         GPIO_IN:  bus.prdata = apb_data_t'(sync2_q);
         default:  bus.prdata = '0;
      endcase
   end

   assign bus.pready = 1'b1;
   assign bus.pslverr = 1'b0;

   assign gpio_out_o = out_q;
   assign gpio_oe_o = dir_q;

endmodule

// File: src/apb_periph_decoder.sv
// APB address decoder
// Tracks setup and access, selects one peripheral by region, muxes the response

module apb_periph_decoder
   import apb_periph_pkg::*;
(
   input  logic         clk_i,
   input  logic         rst_n_i,
   input  logic         psel_i,
   input  logic         penable_i,
   input  logic         pwrite_i,
   input  apb_addr_t    paddr_i,
   input  apb_data_t    pwdata_i,
   output apb_data_t    prdata_o,
   output logic         pready_o,
   output logic         pslverr_o,
   apb_periph_if.master gpio_bus,
   apb_periph_if.master pwm_bus,
   apb_periph_if.master soc_bus
);

   apb_phase_t phase_q;
   slave_sel_t sel_d;
   slave_sel_t sel_q;
   slave_sel_t sel_cur;
   logic       in_access;
   logic [3:0] region;

   assign region = paddr_i[REGION_LSB +: 4];
   assign in_access = (phase_q == PH_ACCESS);

   always_comb begin
      sel_d = SEL_NONE;
      if (psel_i) begin
         case (region)
            REGION_GPIO: sel_d = SEL_GPIO;
            REGION_PWM:  sel_d = SEL_PWM;
            REGION_SOC:  sel_d = SEL_SOC;
            default:     sel_d = SEL_ERR;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         phase_q <= PH_IDLE;
         sel_q <= SEL_NONE;
      end else begin
         case (phase_q)
            PH_IDLE: begin
               if (psel_i && !penable_i) begin
                  phase_q <= PH_ACCESS;
                  sel_q <= sel_d;
               end
            end
            // Zero wait states, access always completes
            default: begin
               phase_q <= PH_IDLE;
               sel_q <= SEL_NONE;
            end
         endcase
      end
   end

   // Live decode in setup, latched choice in access
   assign sel_cur = in_access ? sel_q : sel_d;

   assign gpio_bus.psel = psel_i && (sel_cur == SEL_GPIO);
   assign pwm_bus.psel = psel_i && (sel_cur == SEL_PWM);
   assign soc_bus.psel = psel_i && (sel_cur == SEL_SOC);

   assign gpio_bus.penable = penable_i && in_access && (sel_q == SEL_GPIO);
   assign pwm_bus.penable = penable_i && in_access && (sel_q == SEL_PWM);
   assign soc_bus.penable = penable_i && in_access && (sel_q == SEL_SOC);

   assign gpio_bus.pwrite = pwrite_i;
   assign gpio_bus.paddr = paddr_i;
   assign gpio_bus.pwdata = pwdata_i;
   assign pwm_bus.pwrite = pwrite_i;
   assign pwm_bus.paddr = paddr_i;
   assign pwm_bus.pwdata = pwdata_i;
   assign soc_bus.pwrite = pwrite_i;
   assign soc_bus.paddr = paddr_i;
   assign soc_bus.pwdata = pwdata_i;

   always_comb begin
      prdata_o = '0;
      pready_o = 1'b0;
      pslverr_o = 1'b0;
      if (in_access) begin
         case (sel_q)
            SEL_GPIO: begin
               prdata_o = gpio_bus.prdata;
               pready_o = gpio_bus.pready;
               pslverr_o = gpio_bus.pslverr;
            end
            SEL_PWM: begin
               prdata_o = pwm_bus.prdata;
               pready_o = pwm_bus.pready;
               pslverr_o = pwm_bus.pslverr;
            end
            SEL_SOC: begin
               prdata_o = soc_bus.prdata;
               pready_o = soc_bus.pready;
               pslverr_o = soc_bus.pslverr;
            end
            // Unmapped region answered here
            SEL_ERR: begin
               pready_o = 1'b1;
               pslverr_o = 1'b1;
            end
            default: begin
               pready_o = 1'b0;
            end
         endcase
      end
   end

endmodule

// File: src/apb_periph_if.sv
// APB link between the decoder and one peripheral
// Master modport on the decoder side, slave modport on the peripheral side

interface apb_periph_if
   import apb_periph_pkg::*;
();

   logic      psel;
   logic      penable;
   logic      pwrite;
   apb_addr_t paddr;
   apb_data_t pwdata;
   apb_data_t prdata;
   logic      pready;
   logic      pslverr;

   modport master (
      output psel, penable, pwrite, paddr, pwdata,
      input  prdata, pready, pslverr
   );

   modport slave (
      input  psel, penable, pwrite, paddr, pwdata,
      output prdata, pready, pslverr
   );

endinterface

// File: src/apb_periph_pkg.sv
// Shared definitions for the APB peripheral subsystem
// Bus widths, address map, register offsets and decoder types

package apb_periph_pkg;

   typedef logic [31:0] apb_addr_t;
   typedef logic [31:0] apb_data_t;

   localparam int unsigned NUM_GPIO = 16;
   typedef logic [NUM_GPIO-1:0] gpio_vec_t;

   localparam int unsigned NUM_PWM = 4;
   localparam int unsigned PWM_CNT_W = 16;
   typedef logic [PWM_CNT_W-1:0] pwm_cnt_t;

   // Region field is paddr[11:8]
   localparam int unsigned REGION_LSB = 8;
   localparam logic [3:0] REGION_GPIO = 4'd0;
   localparam logic [3:0] REGION_PWM = 4'd1;
   localparam logic [3:0] REGION_SOC = 4'd2;

   localparam logic [7:0] GPIO_DIR = 8'h00;
   localparam logic [7:0] GPIO_OUT = 8'h04;
   localparam logic [7:0] GPIO_IN = 8'h08;

   localparam logic [7:0] PWM_PERIOD = 8'h00;
   localparam logic [7:0] PWM_ENABLE = 8'h04;
   localparam logic [7:0] PWM_DUTY_BASE = 8'h10;

   localparam logic [7:0] SOC_CTRL = 8'h00;
   localparam logic [7:0] SOC_INFO = 8'h04;
   localparam apb_data_t SOC_INFO_ID = 32'h0A5B_0001;

   typedef enum logic [2:0] {SEL_NONE, SEL_GPIO, SEL_PWM, SEL_SOC, SEL_ERR} slave_sel_t;
   typedef enum logic {PH_IDLE, PH_ACCESS} apb_phase_t;

endpackage

// File: src/apb_periph_subsystem.sv
// APB peripheral subsystem top level
// Decoder plus GPIO, PWM timer and SoC control behind one APB port

module apb_periph_subsystem
   import apb_periph_pkg::*;
(
   input  logic               clk_i,
   input  logic               rst_n_i,
   input  logic               psel_i,
   input  logic               penable_i,
   input  logic               pwrite_i,
   input  apb_addr_t          paddr_i,
   input  apb_data_t          pwdata_i,
   output apb_data_t          prdata_o,
   output logic               pready_o,
   output logic               pslverr_o,
   input  gpio_vec_t          gpio_in_i,
   output gpio_vec_t          gpio_out_o,
   output gpio_vec_t          gpio_oe_o,
   output logic [NUM_PWM-1:0] pwm_o,
   output logic               cluster_rstn_o,
   output logic               cluster_en_sa_boot_o,
   output logic               cluster_fetch_en_o
);

   apb_periph_if gpio_bus ();
   apb_periph_if pwm_bus ();
   apb_periph_if soc_bus ();

   apb_periph_decoder apb_periph_decoder_i (
      .clk_i     ( clk_i     ),
      .rst_n_i   ( rst_n_i   ),
      .psel_i    ( psel_i    ),
      .penable_i ( penable_i ),
      .pwrite_i  ( pwrite_i  ),
      .paddr_i   ( paddr_i   ),
      .pwdata_i  ( pwdata_i  ),
      .prdata_o  ( prdata_o  ),
      .pready_o  ( pready_o  ),
      .pslverr_o ( pslverr_o ),
      .gpio_bus  ( gpio_bus  ),
      .pwm_bus   ( pwm_bus   ),
      .soc_bus   ( soc_bus   )
   );

   apb_gpio_regs apb_gpio_regs_i (
      .clk_i      ( clk_i      ),
      .rst_n_i    ( rst_n_i    ),
      .bus        ( gpio_bus   ),
      .gpio_in_i  ( gpio_in_i  ),
      .gpio_out_o ( gpio_out_o ),
      .gpio_oe_o  ( gpio_oe_o  )
   );

   apb_pwm_timer apb_pwm_timer_i (
      .clk_i   ( clk_i   ),
      .rst_n_i ( rst_n_i ),
      .bus     ( pwm_bus ),
      .pwm_o   ( pwm_o   )
   );

   apb_soc_ctrl apb_soc_ctrl_i (
      .clk_i                ( clk_i                ),
      .rst_n_i              ( rst_n_i              ),
      .bus                  ( soc_bus              ),
      .cluster_rstn_o       ( cluster_rstn_o       ),
      .cluster_en_sa_boot_o ( cluster_en_sa_boot_o ),
      .cluster_fetch_en_o   ( cluster_fetch_en_o   )
   );

endmodule

// File: src/apb_pwm_timer.sv
// Four-channel PWM timer
// Shared period counter, per-channel duty compare, registered outputs

module apb_pwm_timer
   import apb_periph_pkg::*;
(
   input  logic               clk_i,
   input  logic               rst_n_i,
   apb_periph_if.slave        bus,
   output logic [NUM_PWM-1:0] pwm_o
);

   pwm_cnt_t                  period_q;
   logic                      enable_q;
   pwm_cnt_t [NUM_PWM-1:0]    duty_q;
   pwm_cnt_t                  cnt_q;
   logic [PWM_CNT_W:0]        cnt_inc;
   logic                      cnt_wrap;
   logic                      wr_en;
   logic [7:0]                reg_off;

   assign reg_off = bus.paddr[7:0];
   assign wr_en = bus.psel && bus.penable && bus.pwrite;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         period_q <= '0;
         enable_q <= 1'b0;
         duty_q <= '0;
      end else if (wr_en) begin
         if (reg_off == PWM_PERIOD) begin
            period_q <= bus.pwdata[PWM_CNT_W-1:0];
         end
         if (reg_off == PWM_ENABLE) begin
            enable_q <= bus.pwdata[0];
         end
         for (int k = 0; k < NUM_PWM; k++) begin
            if (reg_off == PWM_DUTY_BASE + 8'(4 * k)) begin
               duty_q[k] <= bus.pwdata[PWM_CNT_W-1:0];
            end
         end
      end
   end

   // Extra bit so a period of 0 or 0xFFFF still wraps cleanly
   assign cnt_inc = {1'b0, cnt_q} + (PWM_CNT_W + 1)'(1);
   assign cnt_wrap = (cnt_inc >= {1'b0, period_q});

   always_ff @(posedge clk_i) begin
      if (!rst_n_i || !enable_q) begin
         cnt_q <= '0;
         pwm_o <= '0;
      end else begin
         cnt_q <= cnt_wrap ? '0 : cnt_inc[PWM_CNT_W-1:0];
         for (int k = 0; k < NUM_PWM; k++) begin
            pwm_o[k] <= (cnt_q < duty_q[k]);
         end
      end
   end

   always_comb begin
      bus.prdata = '0;
      if (reg_off == PWM_PERIOD) begin
         bus.prdata = apb_data_t'(period_q);
      end
      if (reg_off == PWM_ENABLE) begin
         bus.prdata = apb_data_t'(enable_q);
      end
      for (int k = 0; k < NUM_PWM; k++) begin
         if (reg_off == PWM_DUTY_BASE + 8'(4 * k)) begin
            bus.prdata = apb_data_t'(duty_q[k]);
         end
      end
   end

   assign bus.pready = 1'b1;
   assign bus.pslverr = 1'b0;

endmodule

// File: src/apb_soc_ctrl.sv
// SoC control registers
// Cluster reset release, standalone boot, fetch enable and ID word

module apb_soc_ctrl
   import apb_periph_pkg::*;
(
   input  logic        clk_i,
   input  logic        rst_n_i,
   apb_periph_if.slave bus,
   output logic        cluster_rstn_o,
   output logic        cluster_en_sa_boot_o,
   output logic        cluster_fetch_en_o
);

   logic [2:0] ctrl_q;
   logic       wr_en;
   logic [7:0] reg_off;

   assign reg_off = bus.paddr[7:0];
   assign wr_en = bus.psel && bus.penable && bus.pwrite;

   // Cluster held in reset until bit 0 is set
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         ctrl_q <= '0;
      end else if (wr_en && (reg_off == SOC_CTRL)) begin
         ctrl_q <= bus.pwdata[2:0];
      end
   end

   always_comb begin
      case (reg_off)
         SOC_CTRL: bus.prdata = apb_data_t'(ctrl_q);
         SOC_INFO: bus.prdata = SOC_INFO_ID;
         default:  bus.prdata = '0;
      endcase
   end

   assign bus.pready = 1'b1;
   assign bus.pslverr = 1'b0;

   assign cluster_rstn_o = ctrl_q[0];
   assign cluster_en_sa_boot_o = ctrl_q[1];
   assign cluster_fetch_en_o = ctrl_q[2];

endmodule

// File: verification/apb_periph_asserts.sv
// Concurrent assertions on the subsystem APB port
// Zero wait state access, pslverr framing and reset values, bound to the top level

module apb_periph_asserts
   import apb_periph_pkg::*;
(
   input logic               clk_i,
   input logic               rst_n_i,
   input logic               psel_i,
   input logic               penable_i,
   input logic               pready_i,
   input logic               pslverr_i,
   input apb_data_t          prdata_i,
   input gpio_vec_t          gpio_out_i,
   input gpio_vec_t          gpio_oe_i,
   input logic [NUM_PWM-1:0] pwm_i,
   input logic               cluster_rstn_i,
   input logic               cluster_en_sa_boot_i,
   input logic               cluster_fetch_en_i
);

   timeunit 1ns;
   timeprecision 1ps;

   logic        in_reset_q;
   int unsigned fail_count = 0;

   // Set once reset has been seen on a previous edge
   always @(posedge clk_i) begin
      in_reset_q <= !rst_n_i;
   end

   access_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (psel_i && penable_i) |-> pready_i)
      else begin
         $error("access cycle without pready");
         fail_count++;
      end

   err_with_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      pslverr_i |-> pready_i)
      else begin
         $error("pslverr raised without pready");
         fail_count++;
      end

   reset_outputs: assert property (@(posedge clk_i)
      (!rst_n_i && in_reset_q) |->
         (!pready_i && !pslverr_i && (prdata_i == '0) && (gpio_out_i == '0) &&
          (gpio_oe_i == '0) && (pwm_i == '0) && !cluster_rstn_i &&
          !cluster_en_sa_boot_i && !cluster_fetch_en_i))
      else begin
         $error("control outputs not zero while reset is held");
         fail_count++;
      end

endmodule

bind apb_periph_subsystem apb_periph_asserts apb_periph_asserts_i (
   .clk_i                ( clk_i                ),
   .rst_n_i              ( rst_n_i              ),
   .psel_i               ( psel_i               ),
   .penable_i            ( penable_i            ),
   .pready_i             ( pready_o             ),
   .pslverr_i            ( pslverr_o            ),
   .prdata_i             ( prdata_o             ),
   .gpio_out_i           ( gpio_out_o           ),
   .gpio_oe_i            ( gpio_oe_o            ),
   .pwm_i                ( pwm_o                ),
   .cluster_rstn_i       ( cluster_rstn_o       ),
   .cluster_en_sa_boot_i ( cluster_en_sa_boot_o ),
   .cluster_fetch_en_i   ( cluster_fetch_en_o   )
);

// File: verification/apb_periph_checker.sv
// Response checker for the APB peripheral subsystem
// Read data, error flag, port levels and PWM high-cycle counts

module apb_periph_checker
   import apb_periph_pkg::*;
(
   input  logic               clk_i,
   input  logic               psel_i,
   input  logic               penable_i,
   input  apb_addr_t          paddr_i,
   input  apb_data_t          prdata_i,
   input  logic               pready_i,
   input  logic               pslverr_i,
   input  gpio_vec_t          gpio_out_i,
   input  gpio_vec_t          gpio_oe_i,
   input  logic [NUM_PWM-1:0] pwm_i,
   input  logic               cluster_rstn_i,
   input  logic               cluster_en_sa_boot_i,
   input  logic               cluster_fetch_en_i,
   input  logic               xfer_chk_i,
   input  logic               read_chk_i,
   input  apb_data_t          exp_data_i,
   input  logic               exp_err_i,
   input  logic               port_chk_i,
   input  logic [1:0]         port_sel_i,
   input  apb_data_t          port_exp_i,
   input  logic               win_on_i,
   input  logic [1:0]         win_chan_i,
   input  apb_data_t          win_exp_i,
   output int unsigned        data_errs_o,
   output int unsigned        flag_errs_o,
   output int unsigned        port_errs_o,
   output int unsigned        pwm_errs_o
);

   timeunit 1ns;
   timeprecision 1ps;

   apb_data_t   port_val;
   apb_data_t   high_cnt_q = '0;
   logic        win_prev_q = 1'b0;
   logic        pwm_bit;
   int unsigned data_errs = 0;
   int unsigned flag_errs = 0;
   int unsigned port_errs = 0;
   int unsigned pwm_errs = 0;

   assign data_errs_o = data_errs;
   assign flag_errs_o = flag_errs;
   assign port_errs_o = port_errs;
   assign pwm_errs_o = pwm_errs;
   assign pwm_bit = pwm_i[win_chan_i];

   always_comb begin
      case (port_sel_i)
         2'd0:    port_val = apb_data_t'(gpio_oe_i);
         2'd1:    port_val = apb_data_t'(gpio_out_i);
         2'd2:    port_val = apb_data_t'({cluster_fetch_en_i, cluster_en_sa_boot_i,
                                          cluster_rstn_i});
         default: port_val = apb_data_t'(pwm_i);
      endcase
   end

   always @(posedge clk_i) begin
      // Completed access cycle
      if (xfer_chk_i && psel_i && penable_i && pready_i) begin
         if (pslverr_i !== exp_err_i) begin
            $display("FAIL %0t: pslverr %0b at 0x%08h, expected %0b",
                     $time, pslverr_i, paddr_i, exp_err_i);
            flag_errs++;
         end
         if (read_chk_i && (prdata_i !== exp_data_i)) begin
            $display("FAIL %0t: read 0x%08h returned 0x%08h, expected 0x%08h",
                     $time, paddr_i, prdata_i, exp_data_i);
            data_errs++;
         end
      end
      if (port_chk_i && (port_val !== port_exp_i)) begin
         $display("FAIL %0t: port group %0d is 0x%08h, expected 0x%08h",
                  $time, port_sel_i, port_val, port_exp_i);
         port_errs++;
      end
      if (win_on_i) begin
         if (win_prev_q) begin
            high_cnt_q <= high_cnt_q + apb_data_t'(pwm_bit);
         end else begin
            high_cnt_q <= apb_data_t'(pwm_bit);
         end
      end else if (win_prev_q && (high_cnt_q !== win_exp_i)) begin
         $display("FAIL %0t: pwm channel %0d high for %0d cycles, expected %0d",
                  $time, win_chan_i, high_cnt_q, win_exp_i);
         pwm_errs++;
      end
      win_prev_q <= win_on_i;
   end

endmodule

// File: verification/apb_periph_stimulus.txt
# columns (hex): op addr data expect err
# op 1 write, 2 read, 3 drive gpio_in, 4 pwm measure (addr channel, data period), 5 port check
5 0 0 0 0
5 1 0 0 0
5 2 0 0 0
5 3 0 0 0
2 0 0 0 0
2 4 0 0 0
2 100 0 0 0
2 200 0 0 0
1 0 ff0f 0 0
1 4 a5c3 0 0
2 0 0 ff0f 0
2 4 0 a5c3 0
5 0 0 ff0f 0
5 1 0 a5c3 0
3 0 3c96 0 0
2 8 0 3c96 0
1 100 a 0 0
1 110 3 0 0
1 114 0 0 0
1 118 a 0 0
1 11c c 0 0
1 104 1 0 0
2 11c 0 c 0
4 0 a 3 0
4 1 a 0 0
4 2 a a 0
4 3 a a 0
1 200 ffffffff 0 0
2 200 0 7 0
1 200 5 0 0
5 2 0 5 0
2 204 0 a5b0001 0
1 204 12345678 0 0
2 204 0 a5b0001 0
1 300 deadbeef 0 1
2 304 0 0 1
2 f00 0 0 1
2 0 0 ff0f 0
2 200 0 5 0

// File: verification/tb_apb_periph.sv
// Testbench top for the APB peripheral subsystem
// Clock, reset, stimulus file reader, APB driver, timeout and summary

module tb_apb_periph
   import apb_periph_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int unsigned MAX_LINES = 128;
   localparam int unsigned RESET_CYCLES = 16;

   logic               clk;
   logic               rst_n;
   logic               psel;
   logic               penable;
   logic               pwrite;
   apb_addr_t          paddr;
   apb_data_t          pwdata;
   apb_data_t          prdata;
   logic               pready;
   logic               pslverr;
   gpio_vec_t          gpio_in;
   gpio_vec_t          gpio_out;
   gpio_vec_t          gpio_oe;
   logic [NUM_PWM-1:0] pwm;
   logic               cluster_rstn;
   logic               cluster_en_sa_boot;
   logic               cluster_fetch_en;

   // Expected values handed to the checker
   logic               xfer_chk;
   logic               read_chk;
   apb_data_t          exp_data;
   logic               exp_err;
   logic               port_chk;
   logic [1:0]         port_sel;
   apb_data_t          port_exp;
   logic               win_on;
   logic [1:0]         win_chan;
   apb_data_t          win_exp;

   int unsigned        data_errs;
   int unsigned        flag_errs;
   int unsigned        port_errs;
   int unsigned        pwm_errs;
   int unsigned        op_errs = 0;
   int unsigned        cycle_cnt = 0;
   int unsigned        cycle_limit = 0;
   int unsigned        n_lines = 0;

   logic [7:0]         op_mem [MAX_LINES];
   apb_addr_t          addr_mem [MAX_LINES];
   apb_data_t          data_mem [MAX_LINES];
   apb_data_t          exp_mem [MAX_LINES];
   logic               err_mem [MAX_LINES];

   apb_periph_subsystem apb_periph_subsystem_i (
      .clk_i                ( clk                ),
      .rst_n_i              ( rst_n              ),
      .psel_i               ( psel               ),
      .penable_i            ( penable            ),
      .pwrite_i             ( pwrite             ),
      .paddr_i              ( paddr              ),
      .pwdata_i             ( pwdata             ),
      .prdata_o             ( prdata             ),
      .pready_o             ( pready             ),
      .pslverr_o            ( pslverr            ),
      .gpio_in_i            ( gpio_in            ),
      .gpio_out_o           ( gpio_out           ),
      .gpio_oe_o            ( gpio_oe            ),
      .pwm_o                ( pwm                ),
      .cluster_rstn_o       ( cluster_rstn       ),
      .cluster_en_sa_boot_o ( cluster_en_sa_boot ),
      .cluster_fetch_en_o   ( cluster_fetch_en   )
   );

   apb_periph_checker apb_periph_checker_i (
      .clk_i                ( clk                ),
      .psel_i               ( psel               ),
      .penable_i            ( penable            ),
      .paddr_i              ( paddr              ),
      .prdata_i             ( prdata             ),
      .pready_i             ( pready             ),
      .pslverr_i            ( pslverr            ),
      .gpio_out_i           ( gpio_out           ),
      .gpio_oe_i            ( gpio_oe            ),
      .pwm_i                ( pwm                ),
      .cluster_rstn_i       ( cluster_rstn       ),
      .cluster_en_sa_boot_i ( cluster_en_sa_boot ),
      .cluster_fetch_en_i   ( cluster_fetch_en   ),
      .xfer_chk_i           ( xfer_chk           ),
      .read_chk_i           ( read_chk           ),
      .exp_data_i           ( exp_data           ),
      .exp_err_i            ( exp_err            ),
      .port_chk_i           ( port_chk           ),
      .port_sel_i           ( port_sel           ),
      .port_exp_i           ( port_exp           ),
      .win_on_i             ( win_on             ),
      .win_chan_i           ( win_chan           ),
      .win_exp_i            ( win_exp            ),
      .data_errs_o          ( data_errs          ),
      .flag_errs_o          ( flag_errs          ),
      .port_errs_o          ( port_errs          ),
      .pwm_errs_o           ( pwm_errs           )
   );

   initial begin
      clk = 1'b0;
      forever begin
         #10 clk = ~clk;
      end
   end

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if ((cycle_limit != 0) && (cycle_cnt >= cycle_limit)) begin
         $display("Timeout after %0d cycles, the stimulus did not complete", cycle_cnt);
         $display(">>> FAIL");
         $finish;
      end
   end

   // Reads all entries and sizes the cycle budget
   task automatic load_stimulus(output bit ok);
      int               fd;
      int               n;
      int unsigned      n_meas;
      int unsigned      max_period;
      logic [8*160-1:0] line;
      logic [31:0]      f_op;
      logic [31:0]      f_addr;
      logic [31:0]      f_data;
      logic [31:0]      f_exp;
      logic [31:0]      f_err;
      ok = 1'b0;
      n_meas = 0;
      max_period = 0;
      fd = $fopen("verification/apb_periph_stimulus.txt", "r");
      if (fd != 0) begin
         while ($fgets(line, fd) != 0) begin
            n = $sscanf(line, "%h %h %h %h %h", f_op, f_addr, f_data, f_exp, f_err);
            if ((n == 5) && (n_lines < MAX_LINES)) begin
               op_mem[n_lines] = f_op[7:0];
               addr_mem[n_lines] = f_addr;
               data_mem[n_lines] = f_data;
               exp_mem[n_lines] = f_exp;
               err_mem[n_lines] = f_err[0];
               if (f_op == 32'h4) begin
                  n_meas++;
                  if (f_data > max_period) begin
                     max_period = f_data;
                  end
               end
               n_lines++;
            end
         end
         $fclose(fd);
         cycle_limit = 4 * n_lines + n_meas * 2 * max_period + 200;
         ok = (n_lines != 0);
      end
   endtask

   // Setup then access, ends on the edge that completes the transfer
   task automatic apb_transfer(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                               input apb_data_t exp_rd, input logic exp_slverr);
      @(posedge clk);
      psel <= 1'b1;
      penable <= 1'b0;
      pwrite <= wr;
      paddr <= addr;
      pwdata <= wdata;
      @(posedge clk);
      penable <= 1'b1;
      xfer_chk <= 1'b1;
      read_chk <= !wr;
      exp_data <= exp_rd;
      exp_err <= exp_slverr;
      do begin
         @(posedge clk);
      end while (!pready);
      psel <= 1'b0;
      penable <= 1'b0;
      xfer_chk <= 1'b0;
      read_chk <= 1'b0;
   endtask

   // Leaves room for the two-flop synchronizer
   task automatic drive_gpio(input apb_data_t value);
      @(posedge clk);
      gpio_in <= value[NUM_GPIO-1:0];
      repeat (3) @(posedge clk);
   endtask

   // One period to settle, then a window of one full period
   task automatic measure_pwm(input logic [1:0] chan, input int unsigned period,
                              input apb_data_t exp_high);
      repeat (period) @(posedge clk);
      @(posedge clk);
      win_chan <= chan;
      win_exp <= exp_high;
      win_on <= 1'b1;
      repeat (period) @(posedge clk);
      win_on <= 1'b0;
   endtask

   task automatic check_port(input logic [1:0] sel, input apb_data_t value);
      @(posedge clk);
      port_chk <= 1'b1;
      port_sel <= sel;
      port_exp <= value;
      @(posedge clk);
      port_chk <= 1'b0;
   endtask

   initial begin
      bit          load_ok;
      int unsigned assert_errs;
      int unsigned total;
      rst_n = 1'b0;
      psel = 1'b0;
      penable = 1'b0;
      pwrite = 1'b0;
      paddr = '0;
      pwdata = '0;
      gpio_in = '0;
      xfer_chk = 1'b0;
      read_chk = 1'b0;
      exp_data = '0;
      exp_err = 1'b0;
      port_chk = 1'b0;
      port_sel = '0;
      port_exp = '0;
      win_on = 1'b0;
      win_chan = '0;
      win_exp = '0;
      load_stimulus(load_ok);
      if (!load_ok) begin
         $display("Stimulus file verification/apb_periph_stimulus.txt is missing or empty");
         $display(">>> FAIL");
         $finish;
      end else begin
         repeat (RESET_CYCLES) @(posedge clk);
         rst_n <= 1'b1;
         for (int i = 0; i < n_lines; i++) begin
            case (op_mem[i])
               8'h1: apb_transfer(1'b1, addr_mem[i], data_mem[i], '0, err_mem[i]);
               8'h2: apb_transfer(1'b0, addr_mem[i], '0, exp_mem[i], err_mem[i]);
               8'h3: drive_gpio(data_mem[i]);
               8'h4: measure_pwm(addr_mem[i][1:0], data_mem[i], exp_mem[i]);
               8'h5: check_port(addr_mem[i][1:0], exp_mem[i]);
               default: begin
                  $display("Unknown operation %0h in stimulus entry %0d", op_mem[i], i);
                  op_errs++;
               end
            endcase
         end
         // Last checker sample lands here
         repeat (2) @(posedge clk);
         assert_errs = apb_periph_subsystem_i.apb_periph_asserts_i.fail_count;
         total = data_errs + flag_errs + port_errs + pwm_errs + assert_errs + op_errs;
         $display("Errors: read data %0d, error flag %0d, ports %0d, pwm %0d, %s %0d, %s %0d",
                  data_errs, flag_errs, port_errs, pwm_errs,
                  "assertions", assert_errs, "stimulus", op_errs);
         if (total == 0) begin
            $display(">>> PASS");
         end else begin
            $display(">>> FAIL");
         end
         $finish;
      end
   end

endmodule
